//--- Makefile
# Verilator build of the issue stage testbench

TOP = tb_issue_core

all: run

compile:
	verilator --binary --assert --timescale 1ns/100ps -f list.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             i_flush,

    // Issue handshake from the reservation station
    input  logic             i_issue_valid,
    input  ooo_pkg::issue_t  i_issue,
    output logic             o_issue_ready,

    // Result handshake to the outside
    output logic             o_res_valid,
    output ooo_pkg::result_t o_res,
    input  logic             i_res_ready
);

    logic             res_valid;
    ooo_pkg::result_t res;
    ooo_pkg::data_t   alu_out;
    logic             issue_fire;
    logic             res_fire;

    assign res_fire   = res_valid && i_res_ready;
    assign issue_fire = i_issue_valid && o_issue_ready;

    // Room when empty or when the held result leaves this cycle
    assign o_issue_ready = !res_valid || i_res_ready;

    // Function table where shifts use the low 5 bits of source b
    always_comb begin
        case (i_issue.op)
            ooo_pkg::ADD: alu_out = i_issue.src_a + i_issue.src_b;
            ooo_pkg::SUB: alu_out = i_issue.src_a - i_issue.src_b;
            ooo_pkg::AND: alu_out = i_issue.src_a & i_issue.src_b;
            ooo_pkg::OR:  alu_out = i_issue.src_a | i_issue.src_b;
            ooo_pkg::XOR: alu_out = i_issue.src_a ^ i_issue.src_b;
            ooo_pkg::SLL: alu_out = i_issue.src_a << i_issue.src_b[4:0];
            ooo_pkg::SRL: alu_out = i_issue.src_a >> i_issue.src_b[4:0];
            ooo_pkg::SLT: begin
                alu_out = ooo_pkg::data_t'($signed(i_issue.src_a) < $signed(i_issue.src_b));
            end
            default: alu_out = '0;
        endcase
    end

    // Valid bit of the result register
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            res_valid <= 1'b0;
        end else if (i_flush) begin
            res_valid <= 1'b0;
        end else if (issue_fire) begin
            res_valid <= 1'b1;
        end else if (res_fire) begin
            res_valid <= 1'b0;
        end
    end

    // The result payload loads only on an issue handshake
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            res.tag  <= i_issue.dst_tag;
            res.data <= alu_out;
        end
    end

    assign o_res_valid = res_valid;
    assign o_res       = res;

    // A stalled result must not change under the consumer
    a_res_hold: assert property (
        @(posedge clk) disable iff (!n_rst)
        (o_res_valid && !i_res_ready && !i_flush) |=> (o_res_valid && $stable(o_res))
    );

endmodule

//--- issue_core.sv
`timescale 1ns/100ps

module issue_core (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               i_flush,

    // Dispatch from the outside
    input  logic               i_disp_valid,
    input  ooo_pkg::dispatch_t i_disp,
    output logic               o_disp_ready,

    // Write-back broadcast from an outside unit
    input  ooo_pkg::cdb_t      i_wb,

    // Results leaving the subsystem
    output logic               o_res_valid,
    output ooo_pkg::result_t   o_res,
    input  logic               i_res_ready
);

    ooo_pkg::cdb_t   cdb [0:ooo_pkg::CDB_DEPTH-1];
    logic            issue_valid;
    ooo_pkg::issue_t issue;
    logic            issue_ready;

    // Bus 0 broadcasts the ALU result at its handshake
    assign cdb[0] = '{en: o_res_valid && i_res_ready, tag: o_res.tag, data: o_res.data};

    // Bus 1 is the outside write-back as it comes
    assign cdb[1] = i_wb;

    reservation_station #(
        .DEPTH (ooo_pkg::RS_DEPTH)
    ) u_rs (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_flush       (i_flush),
        .i_cdb         (cdb),
        .i_disp_valid  (i_disp_valid),
        .i_disp        (i_disp),
        .o_disp_ready  (o_disp_ready),
        .o_issue_valid (issue_valid),
        .o_issue       (issue),
        .i_issue_ready (issue_ready)
    );

    alu_unit u_alu (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_flush       (i_flush),
        .i_issue_valid (issue_valid),
        .i_issue       (issue),
        .o_issue_ready (issue_ready),
        .o_res_valid   (o_res_valid),
        .o_res         (o_res),
        .i_res_ready   (i_res_ready)
    );

endmodule

//--- list.f
ooo_pkg.sv
reservation_station.sv
alu_unit.sv
issue_core.sv
tb_issue_core.sv

//--- ooo_pkg.sv
package ooo_pkg;

    // Operand and result width
    localparam int DATA_W = 32;

    // The dispatcher hands out 16 tags of this width
    localparam int TAG_W = 4;

    // Number of reservation station slots
    localparam int RS_DEPTH = 8;

    // Bus 0 carries the ALU result and bus 1 carries outside write-backs
    localparam int CDB_DEPTH = 2;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // Shifts take the low 5 bits of source b and SLT compares signed
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_t;

    // One source operand that either holds its data or waits on a tag
    typedef struct packed {
        logic  rdy;
        tag_t  tag;
        data_t data;
    } src_t;

    typedef struct packed {
        alu_op_t op;
        tag_t    dst_tag;
        src_t    src_a;
        src_t    src_b;
    } dispatch_t;

    typedef struct packed {
        alu_op_t op;
        tag_t    dst_tag;
        data_t   src_a;
        data_t   src_b;
    } issue_t;

    typedef struct packed {
        logic  en;
        tag_t  tag;
        data_t data;
    } cdb_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
    } result_t;

endpackage

//--- reservation_station.sv
`timescale 1ns/100ps

module reservation_station #(
    parameter int DEPTH = ooo_pkg::RS_DEPTH
) (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               i_flush,

    // Both common data buses are snooped every cycle
    input  ooo_pkg::cdb_t      i_cdb [0:ooo_pkg::CDB_DEPTH-1],

    // Dispatch handshake from the outside
    input  logic               i_disp_valid,
    input  ooo_pkg::dispatch_t i_disp,
    output logic               o_disp_ready,

    // Issue handshake towards the ALU
    output logic               o_issue_valid,
    output ooo_pkg::issue_t    o_issue,
    input  logic               i_issue_ready
);

    // Ages and slot indices share one width since ages stay dense in 0..DEPTH-1
    typedef logic [$clog2(DEPTH)-1:0] age_t;
    typedef logic [DEPTH-1:0]         slot_vec_t;

    typedef struct packed {
        logic             empty;
        age_t             age;
        ooo_pkg::alu_op_t op;
        ooo_pkg::tag_t    dst_tag;
        ooo_pkg::src_t    src_a;
        ooo_pkg::src_t    src_b;
    } slot_t;

    slot_t     slots     [DEPTH];
    slot_t     slots_nxt [DEPTH];
    slot_vec_t empty_vec;
    slot_vec_t ready_vec;
    slot_vec_t issue_sel;
    slot_vec_t disp_sel;
    slot_vec_t older     [DEPTH];
    logic      full;
    logic      disp_fire;
    logic      issue_fire;
    age_t      issue_idx;
    age_t      issue_age;

    // A waiting source picks up the data of any enabled bus with its tag
    // A ready source keeps its data whatever is broadcast
    function automatic ooo_pkg::src_t snoop(
        input ooo_pkg::src_t src,
        input ooo_pkg::cdb_t cdb [0:ooo_pkg::CDB_DEPTH-1]
    );
        ooo_pkg::src_t res;
        res = src;
        for (int c = 0; c < ooo_pkg::CDB_DEPTH; c++) begin
            if (!src.rdy && cdb[c].en && (cdb[c].tag == src.tag)) begin
                res.data = cdb[c].data;
                res.rdy  = 1'b1;
            end
        end
        return res;
    endfunction

    // Slot status vectors
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            empty_vec[i] = slots[i].empty;
            ready_vec[i] = !slots[i].empty && slots[i].src_a.rdy && slots[i].src_b.rdy;
        end
    end

    assign full         = (empty_vec == '0);
    assign o_disp_ready = !full;
    assign disp_fire    = i_disp_valid && o_disp_ready;

    // Lowest empty slot takes the new instruction
    assign disp_sel = {DEPTH{disp_fire}} & (empty_vec & ~(empty_vec - slot_vec_t'(1)));

    // Row i of the age matrix marks every slot that slot i is older than
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            for (int j = 0; j < DEPTH; j++) begin
                older[i][j] = (i == j) ? 1'b1 : (slots[i].age > slots[j].age);
            end
        end
    end

    // A ready slot wins when it is older than every other ready slot
    // Slots that are not ready are masked out of the comparison
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            issue_sel[i] = ready_vec[i] && (&(older[i] | ~ready_vec));
        end
    end

    // Encode the one-hot winner into a slot index
    always_comb begin
        issue_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (issue_sel[i]) begin
                issue_idx = age_t'(i);
            end
        end
    end

    assign issue_age     = slots[issue_idx].age;
    assign o_issue_valid = |issue_sel;
    assign issue_fire    = o_issue_valid && i_issue_ready;

    assign o_issue = '{
        op:      slots[issue_idx].op,
        dst_tag: slots[issue_idx].dst_tag,
        src_a:   slots[issue_idx].src_a.data,
        src_b:   slots[issue_idx].src_b.data
    };

    // Next state of every slot
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slots_nxt[i]       = slots[i];
            slots_nxt[i].src_a = snoop(slots[i].src_a, i_cdb);
            slots_nxt[i].src_b = snoop(slots[i].src_b, i_cdb);

            // Ages of occupied slots stay dense with 0 as the newest
            // A dispatch pushes every slot one step older
            // An issue pulls the slots older than the leaving one a step back
            if (!slots[i].empty) begin
                case ({disp_fire, issue_fire})
                    2'b10: slots_nxt[i].age = slots[i].age + age_t'(1);
                    2'b01: slots_nxt[i].age = slots[i].age - age_t'(slots[i].age > issue_age);
                    2'b11: slots_nxt[i].age = slots[i].age + age_t'(slots[i].age < issue_age);
                    default: slots_nxt[i].age = slots[i].age;
                endcase
            end

            if (issue_fire && issue_sel[i]) begin
                slots_nxt[i].empty = 1'b1;
            end

            // A broadcast in the dispatch cycle itself is not caught by the new entry
            if (disp_sel[i]) begin
                slots_nxt[i].empty   = 1'b0;
                slots_nxt[i].age     = '0;
                slots_nxt[i].op      = i_disp.op;
                slots_nxt[i].dst_tag = i_disp.dst_tag;
                slots_nxt[i].src_a   = i_disp.src_a;
                slots_nxt[i].src_b   = i_disp.src_b;
            end

            if (i_flush) begin
                slots_nxt[i].empty = 1'b1;
            end
        end
    end

    // Reset empties every slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (!n_rst) begin
                slots[i].empty <= 1'b1;
                slots[i].age   <= '0;
            end else begin
                slots[i] <= slots_nxt[i];
            end
        end
    end

    // Distinct ages of occupied slots leave at most one winner
    a_issue_onehot: assert property (
        @(posedge clk) disable iff (!n_rst)
        $onehot0(issue_sel)
    );

    // A lone dispatch takes one slot that was empty, so a full station takes none
    a_disp_not_full: assert property (
        @(posedge clk) disable iff (!n_rst)
        (disp_fire && !issue_fire && !i_flush) |=>
            ($countones(empty_vec) == $past($countones(empty_vec)) - 1)
    );

    // Nothing survives a flush into the next cycle
    a_flush_clears: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_flush |=> !o_issue_valid
    );

endmodule

//--- tb_issue_core.sv
`timescale 1ns/100ps

module tb_issue_core;

    localparam int CLK_PERIOD  = 4;
    localparam int ARITH_N     = 96;
    localparam int N_TAGS      = 2 ** ooo_pkg::TAG_W;
    // Arithmetic takes a few cycles per instruction under random stalls
    localparam int TEST_CYCLES = 5 + ARITH_N * 4 + 200;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 300) * CLK_PERIOD;

    logic               clk;
    logic               n_rst;
    logic               i_flush;
    logic               i_disp_valid;
    ooo_pkg::dispatch_t i_disp;
    logic               o_disp_ready;
    ooo_pkg::cdb_t      i_wb;
    logic               o_res_valid;
    ooo_pkg::result_t   o_res;
    logic               i_res_ready;
    logic               res_fire;

    // A tag is pending in the scoreboard while its armed and done counts differ
    ooo_pkg::data_t exp_data   [N_TAGS];
    int             armed_cnt  [N_TAGS] = '{default: 0};
    int             done_cnt   [N_TAGS] = '{default: 0};
    ooo_pkg::tag_t  order_tags [N_TAGS];
    ooo_pkg::tag_t  ord_wr     = '0;
    ooo_pkg::tag_t  hs_cnt     = '0;
    ooo_pkg::tag_t  next_tag   = '0;
    logic           order_mode = 1'b0;
    logic           bp_mode    = 1'b0;
    logic           res_random = 1'b0;
    int             disp_cnt   = 0;
    int             bp_base    = 0;
    int             seed       = 32'h517e2bab;

    issue_core u_issue_core (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_flush      (i_flush),
        .i_disp_valid (i_disp_valid),
        .i_disp       (i_disp),
        .o_disp_ready (o_disp_ready),
        .i_wb         (i_wb),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res),
        .i_res_ready  (i_res_ready)
    );

    assign res_fire = o_res_valid && i_res_ready;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Reference ALU with shifts by the low 5 bits of b and a signed compare for SLT
    function automatic ooo_pkg::data_t alu_model(input ooo_pkg::alu_op_t op,
                                                 input ooo_pkg::data_t a,
                                                 input ooo_pkg::data_t b);
        case (op)
            ooo_pkg::ADD: return a + b;
            ooo_pkg::SUB: return a - b;
            ooo_pkg::AND: return a & b;
            ooo_pkg::OR:  return a | b;
            ooo_pkg::XOR: return a ^ b;
            ooo_pkg::SLL: return a << b[4:0];
            ooo_pkg::SRL: return a >> b[4:0];
            ooo_pkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:      return '0;
        endcase
    endfunction

    function automatic ooo_pkg::alu_op_t rand_op();
        return ooo_pkg::alu_op_t'(3'($random(seed)));
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            if (armed_cnt[t] != done_cnt[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    // Completed results and accepted dispatches are counted at the clock edge
    always @(posedge clk) begin
        if (res_fire) begin
            done_cnt[o_res.tag] <= done_cnt[o_res.tag] + 1;
            hs_cnt              <= hs_cnt + ooo_pkg::tag_t'(1);
        end
        if (i_disp_valid && o_disp_ready) begin
            disp_cnt <= disp_cnt + 1;
        end
    end

    // Every task starts and ends on a falling edge
    task automatic push(input ooo_pkg::dispatch_t d);
        while (!o_disp_ready) begin
            // Under random stalls the results drain so that a slot frees up
            if (res_random) begin
                i_res_ready = 1'b1;
            end
            @(negedge clk);
        end
        i_disp       = d;
        i_disp_valid = 1'b1;
        if (res_random) begin
            i_res_ready = (($random(seed) & 3) != 0);
        end
        @(negedge clk);
        i_disp_valid = 1'b0;
    endtask

    // An instruction with both sources ready has its result known at dispatch
    task automatic send(input ooo_pkg::alu_op_t op, input ooo_pkg::data_t a,
                        input ooo_pkg::data_t b);
        ooo_pkg::dispatch_t d;
        d.op      = op;
        d.dst_tag = next_tag;
        d.src_a   = '{rdy: 1'b1, tag: '0, data: a};
        d.src_b   = '{rdy: 1'b1, tag: '0, data: b};
        exp_data[next_tag] = alu_model(op, a, b);
        armed_cnt[next_tag]++;
        if (order_mode) begin
            order_tags[ord_wr] = next_tag;
            ord_wr = ord_wr + ooo_pkg::tag_t'(1);
        end
        next_tag = next_tag + ooo_pkg::tag_t'(1);
        push(d);
    endtask

    // Source a waits on a tag and the caller arms the scoreboard once the data is known
    task automatic send_wait(input ooo_pkg::alu_op_t op, input ooo_pkg::tag_t wait_tag,
                             input ooo_pkg::data_t b, output ooo_pkg::tag_t dst);
        ooo_pkg::dispatch_t d;
        d.op      = op;
        d.dst_tag = next_tag;
        d.src_a   = '{rdy: 1'b0, tag: wait_tag, data: '0};
        d.src_b   = '{rdy: 1'b1, tag: '0, data: b};
        dst       = next_tag;
        next_tag  = next_tag + ooo_pkg::tag_t'(1);
        push(d);
    endtask

    task automatic drain();
        i_res_ready = 1'b1;
        while (pending() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_order();
        ord_wr     = hs_cnt;
        order_mode = 1'b1;
    endtask

    // A result must belong to a pending tag and carry the predicted data
    a_res_live: assert property (
        @(posedge clk) disable iff (!n_rst)
        res_fire |-> (armed_cnt[o_res.tag] != done_cnt[o_res.tag])
    ) else fail_run($sformatf("error o_res.tag got %h with no instruction pending on it",
                              o_res.tag));

    a_res_data: assert property (
        @(posedge clk) disable iff (!n_rst)
        res_fire |-> (o_res.data == exp_data[o_res.tag])
    ) else fail_run($sformatf("error o_res.data got %h expected %h for tag %h",
                              o_res.data, exp_data[o_res.tag], o_res.tag));

    // Ready-on-arrival instructions leave in dispatch order
    a_res_order: assert property (
        @(posedge clk) disable iff (!n_rst)
        (res_fire && order_mode) |-> (o_res.tag == order_tags[hs_cnt])
    ) else fail_run($sformatf("error o_res.tag got %h expected %h",
                              o_res.tag, order_tags[hs_cnt]));

    a_res_hold: assert property (
        @(posedge clk) disable iff (!n_rst)
        (o_res_valid && !i_res_ready && !i_flush) |=> (o_res_valid && $stable(o_res))
    ) else fail_run($sformatf("error o_res changed to %h while stalled", o_res));

    // With results stalled the slots and the ALU take exactly RS_DEPTH + 1 instructions
    a_disp_full: assert property (
        @(posedge clk) disable iff (!n_rst)
        bp_mode |-> (o_disp_ready == ((disp_cnt - bp_base) <= ooo_pkg::RS_DEPTH))
    ) else fail_run($sformatf("error o_disp_ready got %h after %0d stalled dispatches",
                              o_disp_ready, disp_cnt - bp_base));

    a_flush_ready: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_flush |=> o_disp_ready
    ) else fail_run($sformatf("error o_disp_ready got %h expected 1 after flush",
                              o_disp_ready));

    a_reset_state: assert property (
        @(posedge clk)
        !n_rst |=> (!o_res_valid && o_disp_ready)
    ) else fail_run($sformatf("error o_res_valid %h o_disp_ready %h after reset",
                              o_res_valid, o_disp_ready));

    initial begin
        #(TIMEOUT_NS);
        fail_run("Watchdog expired before the tests finished");
    end

    initial begin
        int             n;
        ooo_pkg::data_t x;
        ooo_pkg::data_t y;
        ooo_pkg::data_t z;
        ooo_pkg::tag_t  tag_a;
        ooo_pkg::tag_t  tag_b;
        ooo_pkg::alu_op_t op1;
        ooo_pkg::alu_op_t op2;

        n_rst        = 1'b0;
        i_flush      = 1'b0;
        i_disp_valid = 1'b0;
        i_disp       = '0;
        i_wb         = '0;
        i_res_ready  = 1'b1;
        repeat (5) @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);

        // Every opcode in turn with random operands and random result stalls
        start_order();
        res_random = 1'b1;
        for (int i = 0; i < ARITH_N; i++) begin
            send(ooo_pkg::alu_op_t'(3'(i)), $random(seed), $random(seed));
        end
        res_random = 1'b0;
        drain();

        // Queue several instructions behind a stalled result port
        i_res_ready = 1'b0;
        repeat (5) send(rand_op(), $random(seed), $random(seed));
        repeat (3) @(negedge clk);
        drain();
        order_mode = 1'b0;

        // Wake-up by the outside write-back bus only
        op1   = rand_op();
        z     = $random(seed);
        tag_a = next_tag + ooo_pkg::tag_t'(8);
        send_wait(op1, tag_a, z, tag_b);
        repeat (8) @(negedge clk);
        x        = $random(seed);
        i_wb     = '{en: 1'b1, tag: tag_a, data: x};
        exp_data[tag_b] = alu_model(op1, x, z);
        armed_cnt[tag_b]++;
        @(negedge clk);
        i_wb.en = 1'b0;
        drain();

        // Second instruction takes its source from the first one's result bus
        op1   = rand_op();
        op2   = rand_op();
        x     = $random(seed);
        y     = $random(seed);
        z     = $random(seed);
        tag_a = next_tag;
        send(op1, x, y);
        send_wait(op2, tag_a, z, tag_b);
        exp_data[tag_b] = alu_model(op2, alu_model(op1, x, y), z);
        armed_cnt[tag_b]++;
        drain();

        // Fill the slots and the ALU while results are stalled
        start_order();
        i_res_ready = 1'b0;
        bp_base     = disp_cnt;
        bp_mode     = 1'b1;
        n = 0;
        while (o_disp_ready && n < 2 * ooo_pkg::RS_DEPTH) begin
            send(rand_op(), $random(seed), $random(seed));
            n++;
        end
        repeat (4) @(negedge clk);
        bp_mode = 1'b0;
        drain();
        order_mode = 1'b0;

        // Flush a full station so that none of its results may come out
        i_res_ready = 1'b0;
        n = 0;
        while (o_disp_ready && n < 2 * ooo_pkg::RS_DEPTH) begin
            send(rand_op(), $random(seed), $random(seed));
            n++;
        end
        i_flush = 1'b1;
        for (int t = 0; t < N_TAGS; t++) begin
            armed_cnt[t] = done_cnt[t];
        end
        @(negedge clk);
        i_flush     = 1'b0;
        i_res_ready = 1'b1;
        repeat (10) @(negedge clk);
        send(rand_op(), $random(seed), $random(seed));
        drain();

        $display("All tests passed");
        $finish;
    end

endmodule
